// ==== verilog/cpu_pkg.sv ====
// Widths, word types and instruction field positions of the 16-bit core
// Opcode, ALU operation and FSM state enums
package cpu_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int WORD_W    = 16;
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = $clog2(REG_COUNT);
    localparam int IADDR_W   = 11;  // Instruction word address
    localparam int DADDR_W   = 11;  // Data word address
    localparam int IMM_W     = 5;

    typedef logic signed [WORD_W-1:0] word_t;
    typedef logic [REG_IDX_W-1:0]     reg_idx_t;
    typedef logic [IADDR_W-1:0]       iaddr_t;
    typedef logic [DADDR_W-1:0]       daddr_t;

    // ------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------
    localparam int OP_MSB   = 15;
    localparam int OP_LSB   = 13;
    localparam int RS_MSB   = 12;
    localparam int RS_LSB   = 9;
    localparam int RT_MSB   = 8;
    localparam int RT_LSB   = 5;
    localparam int RD_MSB   = 4;
    localparam int RD_LSB   = 1;
    localparam int IMM_MSB  = 4;
    localparam int IMM_LSB  = 0;
    localparam int JT_MSB   = 11;
    localparam int JT_LSB   = 1;
    localparam int FUNC_BIT = 0;    // ADD/SUB and SLT/MULT select

    typedef enum logic [2:0] {
        OP_ADDSUB = 3'b000,
        OP_SLTMUL = 3'b001,
        OP_LW     = 3'b010,
        OP_SW     = 3'b011,
        OP_BEQ    = 3'b100,
        OP_J      = 3'b101
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_MUL
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_IWAIT,
        S_DECODE,
        S_EXECUTE,
        S_MUL_WAIT,
        S_MEM,
        S_MWAIT,
        S_WRITEBACK
    } cpu_state_e;

endpackage

// ==== verilog/cpu_control.sv ====
// Instruction FSM, opcode class decode and registered stall output
module cpu_control (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::opcode_e    i_opcode,
    input  logic                i_func_bit,
    input  logic                i_rs_eq_rt,
    output cpu_pkg::cpu_state_e o_state,
    output cpu_pkg::alu_op_e    o_alu_op,
    output logic                o_wb_load,
    output logic                o_reg_we,
    output logic                o_dmem_we,
    output logic                o_branch_taken,
    output logic                o_jump,
    output logic                o_io_stall
);
    import cpu_pkg::*;

    cpu_state_e state_q;
    cpu_state_e state_d;
    logic       is_rtype;
    logic       is_mem;
    logic       is_load;
    logic       retire;
    logic       stall_q;

    assign is_rtype = (i_opcode == OP_ADDSUB) || (i_opcode == OP_SLTMUL);
    assign is_mem   = (i_opcode == OP_LW) || (i_opcode == OP_SW);
    assign is_load  = (i_opcode == OP_LW);

    // ------------------------------------------------------------
    // State sequencing
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH:    state_d = S_IWAIT;
            S_IWAIT:    state_d = S_DECODE;
            S_DECODE:   state_d = S_EXECUTE;
            S_EXECUTE: begin
                if (is_mem) begin
                    state_d = S_MEM;
                end else if (i_opcode == OP_SLTMUL && i_func_bit) begin
                    state_d = S_MUL_WAIT;     // Product needs one more cycle
                end else if (is_rtype) begin
                    state_d = S_WRITEBACK;
                end else begin
                    state_d = S_FETCH;        // BEQ, J and no-ops retire here
                end
            end
            S_MUL_WAIT: state_d = S_WRITEBACK;
            S_MEM:      state_d = is_load ? S_MWAIT : S_WRITEBACK;
            S_MWAIT:    state_d = S_WRITEBACK;
            default:    state_d = S_FETCH;    // S_WRITEBACK
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    // ALU operation from opcode class and bit 0
    always_comb begin
        case (i_opcode)
            OP_ADDSUB: o_alu_op = i_func_bit ? ALU_SUB : ALU_ADD;
            OP_SLTMUL: o_alu_op = i_func_bit ? ALU_MUL : ALU_SLT;
            default:   o_alu_op = ALU_ADD;
        endcase
    end

    // ------------------------------------------------------------
    // Strobes and retire
    // ------------------------------------------------------------
    assign o_reg_we       = (state_q == S_WRITEBACK) && (is_rtype || is_load);
    assign o_dmem_we      = (state_q == S_MEM) && (i_opcode == OP_SW);
    assign o_branch_taken = (state_q == S_EXECUTE) && (i_opcode == OP_BEQ) && i_rs_eq_rt;
    assign o_jump         = (state_q == S_EXECUTE) && (i_opcode == OP_J);

    assign retire = (state_q == S_WRITEBACK) ||
                    ((state_q == S_EXECUTE) && !is_rtype && !is_mem);

    // Low for one cycle after each retiring state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q <= 1'b1;
        end else begin
            stall_q <= !retire;
        end
    end

    assign o_state    = state_q;
    assign o_wb_load  = is_load;
    assign o_io_stall = stall_q;

endmodule

// ==== verilog/fetch_unit.sv ====
// Program counter, instruction register, branch and jump targets
module fetch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::cpu_state_e i_state,
    input  cpu_pkg::word_t      i_imem_data,
    input  logic                i_branch_taken,
    input  logic                i_jump,
    output cpu_pkg::iaddr_t     o_imem_addr,
    output cpu_pkg::word_t      o_instr
);
    import cpu_pkg::*;

    iaddr_t           pc_q;
    word_t            instr_q;
    logic [IMM_W-1:0] imm;
    iaddr_t           imm_ext;

    assign imm     = instr_q[IMM_MSB:IMM_LSB];
    assign imm_ext = {{(IADDR_W-IMM_W){imm[IMM_W-1]}}, imm};

    // ------------------------------------------------------------
    // PC update
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (i_state == S_DECODE) begin
            pc_q <= pc_q + 1'b1;
        end else if (i_branch_taken) begin
            pc_q <= pc_q + imm_ext;     // PC already past the branch
        end else if (i_jump) begin
            pc_q <= instr_q[JT_MSB:JT_LSB];
        end
    end

    // Memory word settles in IWAIT and is held through DECODE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= '0;
        end else if (i_state == S_DECODE) begin
            instr_q <= i_imem_data;
        end
    end

    assign o_imem_addr = pc_q;

    // Register file indices come straight from memory during DECODE
    assign o_instr = (i_state == S_DECODE) ? i_imem_data : instr_q;

endmodule

// ==== verilog/register_file.sv ====
// Sixteen signed registers, two registered read ports, one write port
module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t i_rs_idx,
    input  cpu_pkg::reg_idx_t i_rt_idx,
    input  cpu_pkg::reg_idx_t i_rd_idx,
    input  logic              i_we,
    input  cpu_pkg::word_t    i_wdata,
    input  logic              i_read_en,
    output cpu_pkg::word_t    o_rs_data,
    output cpu_pkg::word_t    o_rt_data
);
    import cpu_pkg::*;

    word_t regs [REG_COUNT];
    word_t rs_q;
    word_t rt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd_idx] <= i_wdata;
        end
    end

    // Operands held from DECODE until the next instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_q <= '0;
            rt_q <= '0;
        end else if (i_read_en) begin
            rs_q <= regs[i_rs_idx];
            rt_q <= regs[i_rt_idx];
        end
    end

    assign o_rs_data = rs_q;
    assign o_rt_data = rt_q;

endmodule

// ==== verilog/execute_unit.sv ====
// ALU with add, subtract, set-less-than and a two-stage multiplier
// Write-back value register and data address calculation
module execute_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_pkg::alu_op_e          i_alu_op,
    input  cpu_pkg::word_t            i_rs,
    input  cpu_pkg::word_t            i_rt,
    input  logic [cpu_pkg::IMM_W-1:0] i_imm,
    input  cpu_pkg::word_t            i_load_data,
    input  logic                      i_wb_load,
    output cpu_pkg::word_t            o_result,
    output cpu_pkg::daddr_t           o_dmem_addr,
    output logic                      o_rs_eq_rt
);
    import cpu_pkg::*;

    logic [WORD_W-1:0]   pp_lo_q;       // rs times low byte of rt
    logic [WORD_W/2-1:0] pp_hi_q;       // Low byte of rs times high byte of rt
    logic [WORD_W-1:0]   mul_lo;
    logic [WORD_W-1:0]   addr_sum;
    word_t               alu_val;
    word_t               result_q;

    // ------------------------------------------------------------
    // Multiplier
    // ------------------------------------------------------------
    // Low half of the product is the same for signed and unsigned operands
    always_ff @(posedge clk) begin
        pp_lo_q <= $unsigned(i_rs) * {{(WORD_W/2){1'b0}}, i_rt[WORD_W/2-1:0]};
        pp_hi_q <= i_rs[WORD_W/2-1:0] * i_rt[WORD_W-1:WORD_W/2];
    end

    assign mul_lo = pp_lo_q + {pp_hi_q, {(WORD_W/2){1'b0}}};

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_val = i_rs + i_rt;
            ALU_SUB: alu_val = i_rs - i_rt;
            ALU_SLT: alu_val = {{(WORD_W-1){1'b0}}, (i_rs < i_rt)};   // Signed compare
            default: alu_val = mul_lo;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
        end else begin
            result_q <= i_wb_load ? i_load_data : alu_val;
        end
    end

    // Word address wraps at the memory size
    assign addr_sum    = i_rs + {{(WORD_W-IMM_W){i_imm[IMM_W-1]}}, i_imm};
    assign o_dmem_addr = addr_sum[DADDR_W-1:0];

    assign o_rs_eq_rt = (i_rs == i_rt);
    assign o_result   = result_q;

endmodule

// ==== verilog/cpu_top.sv ====
// Top level of the multicycle 16-bit core
// Connects control, fetch, register file and execute to the memory ports
module cpu_top (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::word_t  i_imem_data,
    input  cpu_pkg::word_t  i_dmem_rdata,
    output cpu_pkg::iaddr_t o_imem_addr,
    output cpu_pkg::daddr_t o_dmem_addr,
    output logic            o_dmem_we,
    output cpu_pkg::word_t  o_dmem_wdata,
    output logic            o_io_stall
);
    import cpu_pkg::*;

    cpu_state_e           state;
    alu_op_e              alu_op;
    opcode_e              opcode;
    word_t                instr;
    word_t                rs_data;
    word_t                rt_data;
    word_t                result;
    reg_idx_t             rs_idx;
    reg_idx_t             rt_idx;
    reg_idx_t             rd_idx;
    reg_idx_t             wr_idx;
    logic [IMM_W-1:0]     imm;
    logic                 wb_load;
    logic                 reg_we;
    logic                 branch_taken;
    logic                 jump;
    logic                 rs_eq_rt;
    logic                 read_en;

    // Instruction field split
    assign opcode  = opcode_e'(instr[OP_MSB:OP_LSB]);
    assign rs_idx  = instr[RS_MSB:RS_LSB];
    assign rt_idx  = instr[RT_MSB:RT_LSB];
    assign rd_idx  = instr[RD_MSB:RD_LSB];
    assign imm     = instr[IMM_MSB:IMM_LSB];
    assign wr_idx  = wb_load ? rt_idx : rd_idx;    // LW writes RT
    assign read_en = (state == S_DECODE);

    assign o_dmem_wdata = rt_data;

    cpu_control u_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_opcode       (opcode),
        .i_func_bit     (instr[FUNC_BIT]),
        .i_rs_eq_rt     (rs_eq_rt),
        .o_state        (state),
        .o_alu_op       (alu_op),
        .o_wb_load      (wb_load),
        .o_reg_we       (reg_we),
        .o_dmem_we      (o_dmem_we),
        .o_branch_taken (branch_taken),
        .o_jump         (jump),
        .o_io_stall     (o_io_stall)
    );

    fetch_unit u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_state        (state),
        .i_imem_data    (i_imem_data),
        .i_branch_taken (branch_taken),
        .i_jump         (jump),
        .o_imem_addr    (o_imem_addr),
        .o_instr        (instr)
    );

    register_file u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rs_idx  (rs_idx),
        .i_rt_idx  (rt_idx),
        .i_rd_idx  (wr_idx),
        .i_we      (reg_we),
        .i_wdata   (result),
        .i_read_en (read_en),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_alu_op    (alu_op),
        .i_rs        (rs_data),
        .i_rt        (rt_data),
        .i_imm       (imm),
        .i_load_data (i_dmem_rdata),
        .i_wb_load   (wb_load),
        .o_result    (result),
        .o_dmem_addr (o_dmem_addr),
        .o_rs_eq_rt  (rs_eq_rt)
    );

endmodule

// ==== tests/cpu_tb.sv ====
// Testbench for the multicycle 16-bit core
// Memory models, reference instruction-set model, directed and random programs
module cpu_tb;
    import cpu_pkg::*;

    logic   clk;
    logic   rst_n;
    word_t  imem_data;
    word_t  dmem_rdata;
    iaddr_t imem_addr;
    daddr_t dmem_addr;
    logic   dmem_we;
    word_t  dmem_wdata;
    logic   io_stall;

    word_t  imem [2**IADDR_W];
    word_t  dmem [2**DADDR_W];
    word_t  mdmem [2**DADDR_W];    // Reference model data memory
    daddr_t exp_addr [$];
    word_t  exp_data [$];
    iaddr_t exp_fetch [$];          // PC after each retire
    int     exp_cycles [$];
    iaddr_t emit_ptr;
    iaddr_t halt_addr;
    string  test_name;
    logic   running = 1'b0;
    logic   done = 1'b0;
    int     gap;
    int     retires;
    int     errors = 0;
    int     checks = 0;
    int     failed_tests = 0;
    int     cycle_count = 0;
    int     cycle_limit = 100;

    cpu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_data  (imem_data),
        .i_dmem_rdata (dmem_rdata),
        .o_imem_addr  (imem_addr),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .o_io_stall   (io_stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Both memories answer one edge after the address
    always @(posedge clk) begin
        imem_data <= imem[imem_addr];
        if (dmem_we) begin
            dmem[dmem_addr] = dmem_wdata;
        end else begin
            dmem_rdata <= dmem[dmem_addr];
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, test %s never finished", cycle_count, test_name);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Instruction encoding and program building
    // ------------------------------------------------------------
    function automatic word_t encode_rtype(opcode_e op, reg_idx_t rs, reg_idx_t rt,
                                           reg_idx_t rd, logic f);
        return {op, rs, rt, rd, f};
    endfunction

    function automatic word_t encode_itype(opcode_e op, reg_idx_t rs, reg_idx_t rt,
                                           logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encode_jump(iaddr_t target);
        return {OP_J, 1'b0, target, 1'b0};
    endfunction

    task automatic emit(word_t w);
        imem[emit_ptr] = w;
        emit_ptr++;
    endtask

    // Reset first so the old program cannot touch the new image
    task automatic start_test(string name);
        @(posedge clk);
        rst_n <= 1'b0;
        test_name = name;
        emit_ptr = '0;
        for (int a = 0; a < 2**IADDR_W; a++) begin
            imem[a] = encode_jump(iaddr_t'(a));        // Self loop acts as halt
            dmem[a] = word_t'(a * 16'h9e37 + 16'h00b5);
        end
    endtask

    task automatic load_registers(int n);
        for (int i = 1; i <= n; i++) begin
            emit(encode_itype(OP_LW, 4'd0, reg_idx_t'(i), 5'(i)));
        end
    endtask

    // Instruction-set model that runs until the PC reaches the halt address
    function automatic int run_reference(iaddr_t halt);
        word_t      regs [16];
        word_t      ir;
        word_t      a;
        word_t      b;
        iaddr_t     pc;
        daddr_t     addr;
        logic [4:0] imm;
        int         n;
        int         cyc;
        foreach (regs[i]) regs[i] = '0;
        mdmem = dmem;
        pc = '0;
        n = 0;
        while (pc != halt && n < 4096) begin
            ir = imem[pc];
            a = regs[ir[12:9]];
            b = regs[ir[8:5]];
            imm = ir[4:0];
            addr = daddr_t'(a + {{11{imm[4]}}, imm});
            pc = pc + 1'b1;
            cyc = 4;
            case (opcode_e'(ir[15:13]))
                OP_ADDSUB: begin
                    regs[ir[4:1]] = ir[0] ? a - b : a + b;
                    cyc = 5;
                end
                OP_SLTMUL: begin
                    regs[ir[4:1]] = ir[0] ? word_t'(a * b) : ((a < b) ? 16'sd1 : 16'sd0);
                    cyc = ir[0] ? 6 : 5;
                end
                OP_LW: begin
                    regs[ir[8:5]] = mdmem[addr];
                    cyc = 7;
                end
                OP_SW: begin
                    mdmem[addr] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    cyc = 6;
                end
                OP_BEQ:  if (a == b) pc = pc + {{6{imm[4]}}, imm};
                OP_J:    pc = ir[11:1];
                default: ;
            endcase
            exp_fetch.push_back(pc);
            exp_cycles.push_back(cyc);
            n++;
        end
        return n;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks and the compare process
    // ------------------------------------------------------------
    task automatic check_store(string name, daddr_t exp_a, word_t exp_d,
                               daddr_t act_a, word_t act_d);
        checks++;
        if (act_a !== exp_a || act_d !== exp_d) begin
            errors++;
            $display("ERROR %s: store expected mem[%0d]=%0d, actual mem[%0d]=%0d",
                     name, exp_a, exp_d, act_a, act_d);
        end
    endtask

    task automatic check_count(string name, string what, int exp_n, int act_n);
        checks++;
        if (act_n != exp_n) begin
            errors++;
            $display("ERROR %s: %s expected %0d, actual %0d", name, what, exp_n, act_n);
        end
    endtask

    task automatic check_fetch(string name, iaddr_t exp_a, iaddr_t act_a);
        checks++;
        if (act_a !== exp_a) begin
            errors++;
            $display("ERROR %s: fetch address expected %0d, actual %0d", name, exp_a, act_a);
        end
    endtask

    always @(posedge clk) begin
        if (running && rst_n) begin
            gap++;
            if (dmem_we) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("%s: store to %0d that the model never made", test_name, dmem_addr);
                end else begin
                    check_store(test_name, exp_addr.pop_front(), exp_data.pop_front(),
                                dmem_addr, dmem_wdata);
                end
            end
            if (!io_stall) begin       // One cycle after a retire
                retires++;
                if (exp_cycles.size() == 0) begin
                    errors++;
                    $display("%s: more instructions retired than expected", test_name);
                    done = 1'b1;
                end else begin
                    check_count(test_name, "cycles", exp_cycles.pop_front(), gap);
                    check_fetch(test_name, exp_fetch.pop_front(), imem_addr);
                end
                gap = 0;
                if (imem_addr == halt_addr) done = 1'b1;
                if (done) running = 1'b0;
            end
        end
    end

    task automatic run_program();
        int n;
        int start_errors;
        halt_addr = emit_ptr;
        exp_addr.delete();
        exp_data.delete();
        exp_fetch.delete();
        exp_cycles.delete();
        n = run_reference(halt_addr);
        cycle_limit += 7 * n;
        start_errors = errors;
        repeat (4) @(posedge clk);
        if (io_stall !== 1'b1 || dmem_we !== 1'b0) begin
            errors++;
            $display("%s: stall or store strobe wrong during reset", test_name);
        end
        check_fetch(test_name, '0, imem_addr);
        gap = -1;                      // First FETCH starts after the release edge
        retires = 0;
        done = 1'b0;
        running = 1'b1;
        rst_n <= 1'b1;
        wait (done);
        check_count(test_name, "retires", n, retires);
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%s: %0d expected stores never happened", test_name, exp_addr.size());
        end
        if (errors == start_errors) begin
            $display("PASS %s", test_name);
        end else begin
            failed_tests++;
            $display("FAIL %s with %0d errors", test_name, errors - start_errors);
        end
    endtask

    // ------------------------------------------------------------
    // Programs
    // ------------------------------------------------------------
    initial begin
        word_t rand_word;
        void'($urandom(90));
        rst_n = 1'b0;
        imem_data = '0;
        dmem_rdata = '0;

        start_test("arith");
        dmem[1] = 16'sh7fff;
        dmem[2] = 16'sd1;
        dmem[3] = -16'sd5;
        dmem[4] = 16'sh8000;
        dmem[5] = -16'sd1;
        load_registers(5);
        emit(encode_rtype(OP_ADDSUB, 1, 2, 6, 1'b0));    // Wraps to -32768
        emit(encode_rtype(OP_ADDSUB, 4, 2, 7, 1'b1));    // Wraps to 32767
        emit(encode_rtype(OP_ADDSUB, 3, 5, 8, 1'b1));
        emit(encode_rtype(OP_SLTMUL, 3, 2, 9, 1'b0));
        emit(encode_rtype(OP_SLTMUL, 2, 3, 10, 1'b0));
        emit(encode_rtype(OP_SLTMUL, 4, 5, 11, 1'b0));
        for (int r = 6; r <= 11; r++) begin
            emit(encode_itype(OP_SW, 4'd0, reg_idx_t'(r), 5'(-r)));
        end
        run_program();

        start_test("mult");
        dmem[1] = 16'sd300;
        dmem[2] = -16'sd7;
        dmem[3] = 16'sh8000;
        dmem[4] = -16'sd1;
        dmem[5] = 16'sd255;
        dmem[6] = 16'sd12345;
        load_registers(6);
        for (int k = 1; k <= 6; k++) begin
            emit(encode_rtype(OP_SLTMUL, reg_idx_t'(k), reg_idx_t'(7 - k),
                              reg_idx_t'(6 + k), 1'b1));
            emit(encode_itype(OP_SW, 4'd0, reg_idx_t'(6 + k), 5'(6 + k)));
        end
        run_program();

        start_test("memory");
        dmem[1] = 16'sd100;
        dmem[2] = 16'sd2046;
        dmem[3] = -16'sd300;
        dmem[4] = 16'sd4242;
        dmem[5] = -16'sd1;
        load_registers(5);
        emit(encode_itype(OP_SW, 1, 3, 5'(5)));
        emit(encode_itype(OP_SW, 1, 4, 5'(-3)));
        emit(encode_itype(OP_SW, 2, 3, 5'(3)));          // Wraps to word 1
        emit(encode_itype(OP_SW, 2, 4, 5'(-16)));
        emit(encode_itype(OP_LW, 1, 6, 5'(5)));
        emit(encode_itype(OP_LW, 1, 7, 5'(-3)));
        emit(encode_itype(OP_LW, 2, 8, 5'(3)));
        emit(encode_itype(OP_LW, 2, 9, 5'(-16)));
        emit(encode_itype(OP_LW, 5, 10, 5'(4)));         // Base of -1
        for (int r = 6; r <= 10; r++) begin
            emit(encode_itype(OP_SW, 4'd0, reg_idx_t'(r), 5'(r + 4)));
        end
        run_program();

        start_test("branch");
        dmem[1] = 16'sd5;
        dmem[2] = 16'sd5;
        dmem[3] = 16'sd9;
        dmem[4] = 16'sd3;
        dmem[5] = 16'sd1;
        load_registers(5);
        emit(encode_itype(OP_BEQ, 1, 3, 5'(2)));         // Not taken
        emit(encode_itype(OP_SW, 0, 1, 5'(8)));
        emit(encode_itype(OP_BEQ, 1, 2, 5'(2)));         // Taken to 10
        emit(encode_itype(OP_SW, 0, 3, 5'(9)));
        emit(encode_itype(OP_SW, 0, 3, 5'(10)));
        emit(encode_jump(13));
        emit(encode_itype(OP_SW, 0, 3, 5'(11)));
        emit(encode_itype(OP_SW, 0, 3, 5'(12)));
        emit(encode_rtype(OP_ADDSUB, 4, 5, 4, 1'b1));    // Loop body at 13
        emit(encode_itype(OP_SW, 4, 4, 5'(13)));
        emit(encode_itype(OP_BEQ, 4, 0, 5'(1)));         // Exit when zero
        emit(encode_itype(OP_BEQ, 0, 0, 5'(-4)));        // Back to 13
        run_program();

        // Random R-type, LW and SW only
        start_test("random");
        for (int i = 0; i < 200; i++) begin
            rand_word = word_t'($urandom());
            rand_word[15:13] = 3'($urandom_range(3));
            emit(rand_word);
        end
        run_program();

        $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/cpu_pkg.sv
verilog/cpu_control.sv
verilog/fetch_unit.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/cpu_top.sv
tests/cpu_tb.sv
